//--- list.f
+incdir+source
source/graph_write_pkg.sv
source/edge_write_dispatch.sv
source/edge_data_write_command_control.sv
source/write_request_fifo.sv
source/write_request_arbiter.sv
source/graph_write_top.sv
bench/graph_write_clock_gen.sv
bench/graph_write_checker.sv
bench/graph_write_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f list.f --top-module graph_write_tb -Mdir obj_dir

./obj_dir/Vgraph_write_tb +verilator+error+limit+100 | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi

//--- bench/graph_write_tb.sv
// Base and config are held per test so every request in flight sees the values it was sent with
`timescale 1ns/1ps
`default_nettype none

`include "graph_write_params.svh"

module graph_write_tb;
	import graph_write_pkg::*;

	typedef struct packed {
		logic [2:0]  test;
		logic        en;
		logic        gap;
		cu_config_t  cfg;
		logic [63:0] base;
		logic [2:0]  cu_id;
		logic [31:0] index;
		logic [31:0] data;
	} entry_t;

	logic             clock;
	logic             rstn;
	logic             enabled;
	cu_config_t       cu_config;
	logic [63:0]      base_address;
	edge_data_write_t edge_data_in;
	write_request_t   write_request_out;
	logic [15:0]      drop_count;
	logic             overflow;

	string                  test_names [5] = '{"address_line", "config", "drop_count",
		"enable_gating", "random_burst"};
	entry_t                 table_q [$];
	write_request_payload_t expected_q [`GW_NUM_CU][$];
	cu_config_t             model_cfg;
	logic [15:0]            expected_drops;
	logic [31:0]            rng_state;
	logic                   table_ready = 1'b0;
	int                     current_test;
	int                     checks;
	int                     errors;
	int                     tests_failed;

	graph_write_clock_gen i_clock_gen (
		.clock (clock),
		.rstn  (rstn)
	);

	graph_write_top i_dut (
		.clock             (clock),
		.rstn              (rstn),
		.enabled           (enabled),
		.cu_config         (cu_config),
		.base_address      (base_address),
		.edge_data_in      (edge_data_in),
		.write_request_out (write_request_out),
		.drop_count        (drop_count),
		.overflow          (overflow)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Request as the write rules describe it
	function automatic write_request_payload_t expected_request(input entry_t e,
		input cu_config_t cfg);
		write_request_payload_t r;
		r                  = '0;
		r.address          = e.base + 64'(e.index) * `GW_DATA_BYTES;
		r.size             = 8'(`GW_DATA_BYTES);
		r.command          = cfg.write_ms_sel ? write_ms : write_na;
		r.abt              = abort_mode_t'(cfg.abort_field);
		r.cacheline_offset = e.index[3:0];
		r.cu_id            = e.cu_id;
		r.index            = e.index;
		r.data[e.index[3:0]*32 +: 32] = {e.data[7:0], e.data[15:8], e.data[23:16], e.data[31:24]};
		return r;
	endfunction

	function automatic int pending_count();
		int total;
		total = 0;
		for (int u = 0; u < `GW_NUM_CU; u++) begin
			total += expected_q[u].size();
		end
		return total;
	endfunction

	task automatic compare_value(input string field, input logic [`GW_LINE_BITS-1:0] expected,
		input logic [`GW_LINE_BITS-1:0] actual);
		checks++;
		if (expected !== actual) begin
			$display("FAILED %s %s: expected %0h, actual %0h", test_names[current_test], field,
				expected, actual);
			errors++;
		end
	endtask

	task automatic add_entry(input int test, input logic en, input logic [63:0] cfg,
		input logic [63:0] base, input int cu_id, input logic [31:0] index,
		input logic [31:0] data);
		entry_t e;
		e.test  = 3'(test);
		e.en    = en;
		e.gap   = (test != 4);
		e.cfg   = cfg;
		e.base  = base;
		e.cu_id = 3'(cu_id);
		e.index = index;
		e.data  = data;
		table_q.push_back(e);
	endtask

////////////////////////////////////////////////////////////
// Stimulus table
////////////////////////////////////////////////////////////

	task automatic fill_table();
		logic [31:0] idx;
		int          cu;
		add_entry(0, 1'b1, 64'h1, 64'h10_0000_0000, 0, 32'h0000_0000, 32'h1122_3344);
		add_entry(0, 1'b1, 64'h1, 64'h10_0000_0000, 1, 32'h0000_0005, 32'hdead_beef);
		add_entry(0, 1'b1, 64'h1, 64'h10_0000_0000, 2, 32'h0000_000f, 32'h0102_0304);
		add_entry(0, 1'b1, 64'h1, 64'h10_0000_0000, 3, 32'h0000_0010, 32'hcafe_f00d);
		add_entry(0, 1'b1, 64'h1, 64'h10_0000_0000, 0, 32'h0001_2347, 32'h8000_0001);
		add_entry(0, 1'b1, 64'h1, 64'h10_0000_0000, 1, 32'hffff_fffe, 32'h55aa_33cc);
		add_entry(0, 1'b1, 64'h1, 64'h10_0000_0000, 2, 32'h0000_0009, 32'h0f0e_0d0c);
		add_entry(0, 1'b1, 64'h1, 64'h10_0000_0000, 3, 32'h8000_000b, 32'h7654_3210);
		// write_ms with page, then a zero word, then write_na again
		add_entry(1, 1'b1, 64'ha, 64'h8000_0000, 0, 32'h3, 32'h0000_00a1);
		add_entry(1, 1'b1, 64'h0, 64'h8000_0000, 1, 32'h4, 32'h0000_00b2);
		add_entry(1, 1'b1, 64'h4, 64'h8000_0000, 2, 32'h7, 32'h0000_00c3);
		add_entry(1, 1'b1, 64'h1_0000_0000, 64'h8000_0000, 3, 32'h8, 32'h0000_00d4);
		add_entry(2, 1'b1, 64'h0, 64'h2_0000_0000, 4, 32'h11, 32'h1111_1111);
		add_entry(2, 1'b1, 64'h0, 64'h2_0000_0000, 5, 32'h12, 32'h2222_2222);
		add_entry(2, 1'b1, 64'h0, 64'h2_0000_0000, 1, 32'h13, 32'h3333_3333);
		add_entry(2, 1'b1, 64'h0, 64'h2_0000_0000, 6, 32'h14, 32'h4444_4444);
		add_entry(2, 1'b1, 64'h0, 64'h2_0000_0000, 7, 32'h15, 32'h5555_5555);
		// Disabled writes and config, then one enabled write with a zero word
		add_entry(3, 1'b0, 64'h9, 64'h3_0000_0000, 0, 32'h21, 32'h6666_6666);
		add_entry(3, 1'b0, 64'h9, 64'h3_0000_0000, 2, 32'h22, 32'h7777_7777);
		add_entry(3, 1'b0, 64'h9, 64'h3_0000_0000, 5, 32'h23, 32'h8888_8888);
		add_entry(3, 1'b0, 64'h9, 64'h3_0000_0000, 7, 32'h24, 32'h9999_9999);
		add_entry(3, 1'b1, 64'h0, 64'h3_0000_0000, 3, 32'h25, 32'habcd_ef01);
		for (int i = 0; i < 24; i++) begin
			rng_state = xorshift32(rng_state);
			cu        = int'(rng_state % `GW_NUM_CU);
			rng_state = xorshift32(rng_state);
			idx       = rng_state;
			rng_state = xorshift32(rng_state);
			add_entry(4, 1'b1, 64'hb, 64'hab_cdef_0000, cu, idx, rng_state);
		end
	endtask

	task automatic drive_entry(input entry_t e);
		@(posedge clock);
		enabled      <= e.en;
		cu_config    <= e.cfg;
		base_address <= e.base;
		edge_data_in <= {1'b1, e.cu_id, e.index, e.data};
		if (e.en) begin
			if (e.cfg != '0) begin
				model_cfg = e.cfg;
			end
			if (e.cu_id < `GW_NUM_CU) begin
				expected_q[e.cu_id].push_back(expected_request(e, model_cfg));
			end else begin
				expected_drops++;
			end
		end
		if (e.gap) begin
			@(posedge clock);
			edge_data_in.valid <= 1'b0;
		end
	endtask

	task automatic finish_test(input int first_errors, input int first_checks);
		int waited;
		waited = 0;
		@(posedge clock);
		edge_data_in.valid <= 1'b0;
		while (pending_count() != 0 && waited < 60) begin
			@(posedge clock);
			waited++;
		end
		// Settle time catches stray requests
		repeat (12) @(posedge clock);
		@(negedge clock);
		for (int u = 0; u < `GW_NUM_CU; u++) begin
			if (expected_q[u].size() != 0) begin
				$display("Test %s: unit %0d never delivered %0d expected requests",
					test_names[current_test], u, expected_q[u].size());
				errors++;
			end
		end
		compare_value("drop_count", expected_drops, drop_count);
		compare_value("overflow", 1'b0, overflow);
		if (errors != first_errors) begin
			tests_failed++;
		end
		$display("Test %s finished with %0d checks and %0d errors", test_names[current_test],
			checks - first_checks, errors - first_errors);
	endtask

	task automatic check_request(input write_request_payload_t act);
		write_request_payload_t exp;
		if (act.cu_id >= `GW_NUM_CU || expected_q[act.cu_id].size() == 0) begin
			$display("Test %s: request for unit %0d arrived when none was expected",
				test_names[current_test], act.cu_id);
			errors++;
		end else begin
			exp = expected_q[act.cu_id].pop_front();
			compare_value("address", exp.address, act.address);
			compare_value("size", exp.size, act.size);
			compare_value("command", exp.command, act.command);
			compare_value("abt", exp.abt, act.abt);
			compare_value("cacheline_offset", exp.cacheline_offset, act.cacheline_offset);
			compare_value("index", exp.index, act.index);
			compare_value("data", exp.data, act.data);
		end
	endtask

	// Output monitor away from the rising edge
	always @(negedge clock) begin
		if (rstn && write_request_out.valid) begin
			check_request(write_request_out.payload);
		end
	end

	initial begin : watchdog
		wait (table_ready);
		repeat (20 * table_q.size() + 100) @(posedge clock);
		$display("Watchdog expired before the tests completed");
		$display("SOME TESTS FAILED");
		$finish;
	end

////////////////////////////////////////////////////////////
// Main sequence
////////////////////////////////////////////////////////////

	initial begin : main_sequence
		int first_errors;
		int first_checks;
		enabled        = 1'b0;
		cu_config      = '0;
		base_address   = '0;
		edge_data_in   = '0;
		model_cfg      = '0;
		expected_drops = '0;
		rng_state      = 32'h554e_4ef2;
		checks         = 0;
		errors         = 0;
		tests_failed   = 0;
		current_test   = 0;
		first_errors   = 0;
		first_checks   = 0;
		fill_table();
		table_ready = 1'b1;
		wait (rstn === 1'b1);
		for (int i = 0; i < table_q.size(); i++) begin
			if (i == 0 || table_q[i].test != table_q[i-1].test) begin
				current_test = table_q[i].test;
				first_errors = errors;
				first_checks = checks;
			end
			drive_entry(table_q[i]);
			if (i == table_q.size() - 1 || table_q[i+1].test != table_q[i].test) begin
				finish_test(first_errors, first_checks);
			end
		end
		$display("Summary: %0d tests failed, %0d checks, %0d errors, %0d assertion failures",
			tests_failed, checks, errors, i_dut.i_checker.failures);
		if (errors == 0 && i_dut.i_checker.failures == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/graph_write_checker.sv
// Address check holds only while base_address stays steady for the requests in flight
`timescale 1ns/1ps
`default_nettype none

`include "graph_write_params.svh"

module graph_write_checker (
	input logic                            clock,
	input logic                            rstn,
	input logic [63:0]                     base_address,
	input graph_write_pkg::write_request_t write_request_out,
	input logic [15:0]                     drop_count,
	input logic                            overflow
);
	import graph_write_pkg::*;

	int unsigned failures = 0;

	no_valid_in_reset: assert property (@(posedge clock) !rstn |-> !write_request_out.valid)
		else begin
			$error("request valid while reset is asserted");
			failures++;
		end

	drops_monotonic: assert property (@(posedge clock) disable iff (!rstn)
		drop_count >= $past(drop_count))
		else begin
			$error("drop_count decreased");
			failures++;
		end

	// Overflow is sticky until reset
	overflow_sticky: assert property (@(posedge clock) disable iff (!rstn) !$fell(overflow))
		else begin
			$error("overflow fell without reset");
			failures++;
		end

	address_scaled: assert property (@(posedge clock) disable iff (!rstn)
		write_request_out.valid |-> write_request_out.payload.address ==
			base_address + 64'(write_request_out.payload.index) * `GW_DATA_BYTES)
		else begin
			$error("request address does not match base plus scaled index");
			failures++;
		end

endmodule

bind graph_write_top graph_write_checker i_checker (
	.clock             (clock),
	.rstn              (rstn),
	.base_address      (base_address),
	.write_request_out (write_request_out),
	.drop_count        (drop_count),
	.overflow          (overflow)
);

`default_nettype wire

//--- bench/graph_write_clock_gen.sv
// Free-running 8 ns clock from time zero, reset released after the second rising edge
`timescale 1ns/1ps
`default_nettype none

module graph_write_clock_gen (
	output logic clock,
	output logic rstn
);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// Reset held low for two cycles
	initial begin
		rstn = 1'b0;
		repeat (2) @(posedge clock);
		rstn <= 1'b1;
	end

endmodule

`default_nettype wire

//--- source/graph_write_top.sv
// Plain valid strobes throughout, so a full unit queue loses requests and raises overflow
`timescale 1ns/1ps
`default_nettype none

`include "graph_write_params.svh"

module graph_write_top (
	input  logic                              clock,
	input  logic                              rstn,
	input  logic                              enabled,
	input  graph_write_pkg::cu_config_t       cu_config,
	input  logic [63:0]                       base_address,
	input  graph_write_pkg::edge_data_write_t edge_data_in,
	output graph_write_pkg::write_request_t   write_request_out,
	output logic [15:0]                       drop_count,
	output logic                              overflow
);
	import graph_write_pkg::*;

	edge_data_write_t edge_data_unit [`GW_NUM_CU];
	write_request_t   write_request_unit [`GW_NUM_CU];

	edge_write_dispatch u_dispatch (
		.clock          (clock),
		.rstn           (rstn),
		.enabled        (enabled),
		.edge_data_in   (edge_data_in),
		.edge_data_unit (edge_data_unit),
		.drop_count     (drop_count)
	);

	// One command builder per compute unit
	for (genvar u = 0; u < `GW_NUM_CU; u++) begin : g_cu
		edge_data_write_command_control u_control (
			.clock           (clock),
			.rstn            (rstn),
			.enabled         (enabled),
			.cu_config       (cu_config),
			.base_address    (base_address),
			.edge_data_write (edge_data_unit[u]),
			.write_request   (write_request_unit[u])
		);
	end

	write_request_arbiter u_arbiter (
		.clock              (clock),
		.rstn               (rstn),
		.write_request_unit (write_request_unit),
		.write_request_out  (write_request_out),
		.overflow           (overflow)
	);

endmodule

`default_nettype wire

//--- source/write_request_arbiter.sv
// Drains one request per cycle with no back-pressure from the port, overflow clears only at reset
`timescale 1ns/1ps
`default_nettype none

`include "graph_write_params.svh"

module write_request_arbiter (
	input  logic                            clock,
	input  logic                            rstn,
	input  graph_write_pkg::write_request_t write_request_unit [`GW_NUM_CU],
	output graph_write_pkg::write_request_t write_request_out,
	output logic                            overflow
);
	import graph_write_pkg::*;

	localparam int unit_bits = $clog2(`GW_NUM_CU);

	write_request_t         pop_data [`GW_NUM_CU];
	logic [`GW_NUM_CU-1:0]  empty;
	logic [`GW_NUM_CU-1:0]  pop;
	logic [`GW_NUM_CU-1:0]  dropped;
	logic [unit_bits-1:0]   last_served;
	logic [unit_bits-1:0]   grant_idx;
	logic                   grant_found;
	logic                   out_valid;
	write_request_payload_t out_payload;

	for (genvar u = 0; u < `GW_NUM_CU; u++) begin : g_queue
		write_request_fifo u_fifo (
			.clock     (clock),
			.rstn      (rstn),
			.push      (write_request_unit[u].valid),
			.push_data (write_request_unit[u]),
			.pop       (pop[u]),
			.pop_data  (pop_data[u]),
			.empty     (empty[u]),
			.dropped   (dropped[u])
		);
		assign pop[u] = grant_found && (grant_idx == u);
	end

	// Search starts just past the unit served last
	always_comb begin : pick_next
		int cand;
		grant_found = 1'b0;
		grant_idx   = last_served;
		for (int i = 1; i <= `GW_NUM_CU; i++) begin
			cand = (int'(last_served) + i) % `GW_NUM_CU;
			if (!grant_found && !empty[cand]) begin
				grant_found = 1'b1;
				grant_idx   = unit_bits'(cand);
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			last_served <= '0;
			out_valid   <= 1'b0;
			overflow    <= 1'b0;
		end else begin
			out_valid <= grant_found;
			if (grant_found) begin
				last_served <= grant_idx;
			end
			if (|dropped) begin
				overflow <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		out_payload <= pop_data[grant_idx].payload;
	end

	assign write_request_out.valid   = out_valid;
	assign write_request_out.payload = out_payload;

endmodule

`default_nettype wire

//--- source/write_request_fifo.sv
// A push into a full queue is lost even when a pop happens in the same cycle
`timescale 1ns/1ps
`default_nettype none

`include "graph_write_params.svh"

module write_request_fifo (
	input  logic                            clock,
	input  logic                            rstn,
	input  logic                            push,
	input  graph_write_pkg::write_request_t push_data,
	input  logic                            pop,
	output graph_write_pkg::write_request_t pop_data,
	output logic                            empty,
	output logic                            dropped
);
	import graph_write_pkg::*;

	localparam int ptr_bits = $clog2(`GW_FIFO_DEPTH);
	localparam logic [ptr_bits:0] depth = `GW_FIFO_DEPTH;
	localparam logic [ptr_bits-1:0] last_slot = ptr_bits'(`GW_FIFO_DEPTH - 1);

	write_request_payload_t mem [`GW_FIFO_DEPTH];
	logic [ptr_bits-1:0]    wr_ptr;
	logic [ptr_bits-1:0]    rd_ptr;
	logic [ptr_bits:0]      count;
	logic                   full;
	logic                   do_push;
	logic                   do_pop;

	assign full    = (count == depth);
	assign empty   = (count == '0);
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			dropped <= 1'b0;
		end else begin
			dropped <= push && full;
			if (do_push) begin
				wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + (do_push ? 1'b1 : 1'b0) - (do_pop ? 1'b1 : 1'b0);
		end
	end

	// Storage
	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data.payload;
		end
	end

	assign pop_data.valid   = !empty;
	assign pop_data.payload = mem[rd_ptr];

endmodule

`default_nettype wire

//--- source/edge_data_write_command_control.sv
// Three-stage pipeline, config is taken only when nonzero and enabled, base is sampled at entry
`timescale 1ns/1ps
`default_nettype none

`include "graph_write_params.svh"

module edge_data_write_command_control (
	input  logic                              clock,
	input  logic                              rstn,
	input  logic                              enabled,
	input  graph_write_pkg::cu_config_t       cu_config,
	input  logic [63:0]                       base_address,
	input  graph_write_pkg::edge_data_write_t edge_data_write,
	output graph_write_pkg::write_request_t   write_request
);
	import graph_write_pkg::*;

	localparam int scale_shift = $clog2(`GW_DATA_BYTES);

	cu_config_t                 config_latched;
	logic                       in_valid;
	edge_data_write_payload_t   in_payload;
	logic [63:0]                base_latched;
	logic [`GW_OFFSET_BITS-1:0] slot;
	abort_mode_t                abt_decoded;
	write_request_payload_t     next_payload;
	logic                       build_valid;
	write_request_payload_t     build_payload;
	logic                       out_valid;
	write_request_payload_t     out_payload;

////////////////////////////////////////////////////////////
// Stage 1, input latch
////////////////////////////////////////////////////////////

	// Last nonzero word stays in force
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			config_latched <= '0;
			in_valid       <= 1'b0;
		end else begin
			if (enabled && (|cu_config)) begin
				config_latched <= cu_config;
			end
			in_valid <= edge_data_write.valid;
		end
	end

	always_ff @(posedge clock) begin
		in_payload   <= edge_data_write.payload;
		base_latched <= base_address;
	end

////////////////////////////////////////////////////////////
// Stage 2, request build
////////////////////////////////////////////////////////////

	always_comb begin
		slot = in_payload.index[`GW_OFFSET_BITS-1:0];

		case (config_latched.abort_field)
			3'd1:    abt_decoded = abt_abort;
			3'd2:    abt_decoded = abt_page;
			3'd3:    abt_decoded = abt_pref;
			3'd4:    abt_decoded = abt_spec;
			default: abt_decoded = abt_strict;
		endcase

		next_payload                  = '0;
		next_payload.address          = base_latched + ({32'b0, in_payload.index} << scale_shift);
		next_payload.size             = 8'(`GW_DATA_BYTES);
		next_payload.command          = config_latched.write_ms_sel ? write_ms : write_na;
		next_payload.abt              = abt_decoded;
		next_payload.cacheline_offset = slot;
		next_payload.cu_id            = in_payload.cu_id;
		next_payload.index            = in_payload.index;

		// Swapped value lands in its slot, rest of line stays zero
		for (int s = 0; s < `GW_LINE_SLOTS; s++) begin
			if (slot == s) begin
				next_payload.data[s*`GW_DATA_BITS +: `GW_DATA_BITS] =
					swap_data_bytes(in_payload.data);
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			build_valid <= 1'b0;
		end else begin
			build_valid <= in_valid;
		end
	end

	always_ff @(posedge clock) begin
		build_payload <= next_payload;
	end

////////////////////////////////////////////////////////////
// Stage 3, output register
////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= build_valid;
		end
	end

	always_ff @(posedge clock) begin
		out_payload <= build_payload;
	end

	assign write_request.valid   = out_valid;
	assign write_request.payload = out_payload;

endmodule

`default_nettype wire

//--- source/edge_write_dispatch.sv
// Writes are accepted only while enabled is high, and the 16-bit drop counter wraps silently
`timescale 1ns/1ps
`default_nettype none

`include "graph_write_params.svh"

module edge_write_dispatch (
	input  logic                              clock,
	input  logic                              rstn,
	input  logic                              enabled,
	input  graph_write_pkg::edge_data_write_t edge_data_in,
	output graph_write_pkg::edge_data_write_t edge_data_unit [`GW_NUM_CU],
	output logic [15:0]                       drop_count
);
	import graph_write_pkg::*;

	localparam logic [`GW_CU_ID_BITS:0] num_cu = `GW_NUM_CU;

	logic                     accept;
	logic                     unmapped;
	logic [`GW_NUM_CU-1:0]    unit_valid;
	edge_data_write_payload_t unit_payload;

	assign accept   = enabled && edge_data_in.valid;
	assign unmapped = {1'b0, edge_data_in.payload.cu_id} >= num_cu;

	// One valid per unit, only the addressed one rises
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			unit_valid <= '0;
		end else begin
			for (int u = 0; u < `GW_NUM_CU; u++) begin
				unit_valid[u] <= accept && ({1'b0, edge_data_in.payload.cu_id} == u);
			end
		end
	end

	// Payload is shared by every unit
	always_ff @(posedge clock) begin
		unit_payload <= edge_data_in.payload;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			drop_count <= '0;
		end else if (accept && unmapped) begin
			drop_count <= drop_count + 16'd1;
		end
	end

	for (genvar u = 0; u < `GW_NUM_CU; u++) begin : g_unit_out
		assign edge_data_unit[u].valid   = unit_valid[u];
		assign edge_data_unit[u].payload = unit_payload;
	end

endmodule

`default_nettype wire

//--- source/graph_write_pkg.sv
// Types shared by RTL and bench, and abort codes above 4 in the config are treated as strict
`default_nettype none

`include "graph_write_params.svh"

package graph_write_pkg;

	typedef enum logic [2:0] {
		abt_strict = 3'd0,
		abt_abort  = 3'd1,
		abt_page   = 3'd2,
		abt_pref   = 3'd3,
		abt_spec   = 3'd4
	} abort_mode_t;

	typedef enum logic [1:0] {
		write_na = 2'd0,
		write_ms = 2'd1
	} write_cmd_code_t;

	// Host configuration word, only the low bits are decoded
	typedef struct packed {
		logic [59:0] reserved;
		logic        write_ms_sel;
		logic [2:0]  abort_field;
	} cu_config_t;

	typedef struct packed {
		logic [`GW_CU_ID_BITS-1:0] cu_id;
		logic [31:0]               index;
		logic [31:0]               data;
	} edge_data_write_payload_t;

	typedef struct packed {
		logic                     valid;
		edge_data_write_payload_t payload;
	} edge_data_write_t;

	typedef struct packed {
		logic [63:0]                address;
		logic [7:0]                 size;
		write_cmd_code_t            command;
		abort_mode_t                abt;
		logic [`GW_OFFSET_BITS-1:0] cacheline_offset;
		logic [`GW_CU_ID_BITS-1:0]  cu_id;
		logic [31:0]                index;
		logic [`GW_LINE_BITS-1:0]   data;
	} write_request_payload_t;

	typedef struct packed {
		logic                   valid;
		write_request_payload_t payload;
	} write_request_t;

	// Reverse byte order of one element for the memory side
	function automatic logic [`GW_DATA_BITS-1:0] swap_data_bytes(
		input logic [`GW_DATA_BITS-1:0] value
	);
		logic [`GW_DATA_BITS-1:0] swapped;
		for (int b = 0; b < `GW_DATA_BYTES; b++) begin
			swapped[b*8 +: 8] = value[(`GW_DATA_BYTES-1-b)*8 +: 8];
		end
		return swapped;
	endfunction

endpackage

`default_nettype wire

//--- source/graph_write_params.svh
// Element size must be a power of two dividing the line, and at least two units are assumed
`ifndef GRAPH_WRITE_PARAMS_SVH
`define GRAPH_WRITE_PARAMS_SVH

// Controllers behind the dispatcher
`define GW_NUM_CU 4
// Id width leaves room for ids that have no controller
`define GW_CU_ID_BITS 3

// Entries in each per-unit request queue
`define GW_FIFO_DEPTH 4

// Element and line geometry
`define GW_DATA_BYTES 4
`define GW_DATA_BITS (`GW_DATA_BYTES * 8)
`define GW_LINE_BYTES 64
`define GW_LINE_BITS (`GW_LINE_BYTES * 8)
`define GW_LINE_SLOTS (`GW_LINE_BYTES / `GW_DATA_BYTES)
`define GW_OFFSET_BITS 4

`endif
